// File: design/snowflake_pkg.sv
// Shared widths, address map and register offsets for the bus and peripheral side.
// SSD_REFRESH is sized for simulation, so a board build needs a larger value.
`default_nettype none

package snowflake_pkg;

  // ========================================
  // Bus payload types
  // ========================================
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  mask_t;

  // Segment A is bit 0, segment G is bit 6
  typedef logic [6:0]  seg_t;

  // ========================================
  // Memory and address map
  // ========================================
  localparam int MEM_KB = 4;
  localparam int MEM_AW = 10;

  // Upper half of a data address that selects the register block
  localparam logic [15:0] SYS_REGION = 16'h0001;

  // Register word offsets, taken from address bits 7 to 2
  localparam logic [5:0] REG_LEDR   = 6'd0;
  localparam logic [5:0] REG_LEDG   = 6'd1;
  localparam logic [5:0] REG_SSD_EN = 6'd2;
  localparam logic [5:0] REG_SSD_A  = 6'd3;
  localparam logic [5:0] REG_SSD_B  = 6'd4;

  // Clock cycles each display digit stays lit
  localparam int SSD_REFRESH = 64;

endpackage

`default_nettype wire

// File: design/snowflake_bus_if.sv
// Word-wide memory-style bus: en performs one access at the rising edge.
// Read data is valid in the cycle after the access.
`default_nettype none

interface snowflake_bus_if;

  snowflake_pkg::addr_t addr;
  snowflake_pkg::word_t wdata;
  snowflake_pkg::word_t rdata;
  logic                 en;
  logic                 wr_en;
  snowflake_pkg::mask_t mask;

  // Requesting side
  modport master (
    output addr, wdata, en, wr_en, mask,
    input  rdata
  );

  // Responding side
  modport slave (
    input  addr, wdata, en, wr_en, mask,
    output rdata
  );

endinterface

`default_nettype wire

// File: design/generic_spram.sv
// Single-port synchronous RAM with byte write masks, read latency of one cycle.
// Addresses wrap modulo the memory size; contents are not reset.
`default_nettype none

module generic_spram #(
  parameter int KB = snowflake_pkg::MEM_KB
) (
  input  logic           clk,
  snowflake_bus_if.slave bus
);

  localparam int DEPTH = KB * 256;
  localparam int AW    = $clog2(DEPTH);

  snowflake_pkg::word_t ram [DEPTH];
  logic [AW-1:0]        idx;

  // Word index, byte offset dropped
  assign idx = bus.addr[AW+1:2];

  always_ff @(posedge clk) begin
    if (bus.en) begin
      if (bus.wr_en) begin
        for (int i = 0; i < 4; i++) begin
          if (bus.mask[i]) begin
            ram[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
      end else begin
        // Holds the last read word until the next read
        bus.rdata <= ram[idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/snowflake_sys_regs.sv
// LED and display registers; writes need mask bit 0, unmapped offsets read zero.
`default_nettype none

module snowflake_sys_regs (
  input  logic                clk,
  input  logic                rstz,
  snowflake_bus_if.slave      bus,
  output logic                led_r,
  output logic                led_g,
  output logic                ssd_en,
  output snowflake_pkg::seg_t ssd_a,
  output snowflake_pkg::seg_t ssd_b
);

  logic [5:0] offset;
  logic       wr_hit;

  assign offset = bus.addr[7:2];
  assign wr_hit = bus.en && bus.wr_en && bus.mask[0];

  // ========================================
  // Register writes
  // ========================================
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      led_r  <= 1'b0;
      led_g  <= 1'b0;
      ssd_en <= 1'b0;
      ssd_a  <= '0;
      ssd_b  <= '0;
    end else if (wr_hit) begin
      case (offset)
        snowflake_pkg::REG_LEDR:   led_r  <= bus.wdata[0];
        snowflake_pkg::REG_LEDG:   led_g  <= bus.wdata[0];
        snowflake_pkg::REG_SSD_EN: ssd_en <= bus.wdata[0];
        snowflake_pkg::REG_SSD_A:  ssd_a  <= bus.wdata[6:0];
        snowflake_pkg::REG_SSD_B:  ssd_b  <= bus.wdata[6:0];
        default: ;
      endcase
    end
  end

  // ========================================
  // Readback, zero-extended
  // ========================================
  always_ff @(posedge clk) begin
    if (bus.en && !bus.wr_en) begin
      case (offset)
        snowflake_pkg::REG_LEDR:   bus.rdata <= snowflake_pkg::word_t'(led_r);
        snowflake_pkg::REG_LEDG:   bus.rdata <= snowflake_pkg::word_t'(led_g);
        snowflake_pkg::REG_SSD_EN: bus.rdata <= snowflake_pkg::word_t'(ssd_en);
        snowflake_pkg::REG_SSD_A:  bus.rdata <= snowflake_pkg::word_t'(ssd_a);
        snowflake_pkg::REG_SSD_B:  bus.rdata <= snowflake_pkg::word_t'(ssd_b);
        default:                   bus.rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/snowflake_7sd_driver.sv
// Two-digit seven-segment multiplexer, digit swaps every SSD_REFRESH cycles.
// Disabled display is blank with sel low.
`default_nettype none

module snowflake_7sd_driver (
  input  logic                clk,
  input  logic                rstz,
  input  logic                en,
  input  snowflake_pkg::seg_t a,
  input  snowflake_pkg::seg_t b,
  output snowflake_pkg::seg_t disp,
  output logic                sel
);

  localparam int CW = $clog2(snowflake_pkg::SSD_REFRESH);

  logic [CW-1:0] cnt;
  logic          cnt_last;

  assign cnt_last = (cnt == CW'(snowflake_pkg::SSD_REFRESH - 1));

  // Refresh counter and digit select
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      cnt <= '0;
      sel <= 1'b0;
    end else if (!en) begin
      cnt <= '0;
      sel <= 1'b0;
    end else if (cnt_last) begin
      cnt <= '0;
      sel <= ~sel;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Digit a on sel low, digit b on sel high
  assign disp = !en ? '0 : (sel ? b : a);

endmodule

`default_nettype wire

// File: design/snowflake_system_bus.sv
// Two core ports onto memory and the register block, data port has memory priority.
// One access outstanding per port; ack is a single-cycle pulse one cycle after accept.
`default_nettype none

module snowflake_system_bus (
  input  logic                 clk,
  input  logic                 rstz,
  input  snowflake_pkg::addr_t instr_addr,
  input  logic                 instr_req,
  output snowflake_pkg::word_t instr_data,
  output logic                 instr_ack,
  input  snowflake_pkg::addr_t data_addr,
  input  snowflake_pkg::word_t data_wr_data,
  input  snowflake_pkg::mask_t data_mask,
  input  logic                 data_wr_en,
  input  logic                 data_req,
  output snowflake_pkg::word_t data_rd_data,
  output logic                 data_ack,
  snowflake_bus_if.master      mem,
  snowflake_bus_if.master      sys
);

  logic                 data_is_sys;
  logic                 data_go;
  logic                 data_mem_go;
  logic                 data_sys_go;
  logic                 instr_go;
  logic                 data_from_sys;
  snowflake_pkg::addr_t instr_word_addr;

  // ========================================
  // Decode and arbitration
  // ========================================
  assign data_is_sys = (data_addr[31:16] == snowflake_pkg::SYS_REGION);

  // A port cannot start a new access during its own ack cycle
  assign data_go     = data_req && !data_ack;
  assign data_mem_go = data_go && !data_is_sys;
  assign data_sys_go = data_go && data_is_sys;

  // Fetch waits whenever the data port takes memory
  assign instr_go = instr_req && !instr_ack && !data_mem_go;

  // Fetch address folded onto the memory word range
  assign instr_word_addr = snowflake_pkg::addr_t'(
    {instr_addr[snowflake_pkg::MEM_AW+1:2], 2'b00});

  // ========================================
  // Slave requests
  // ========================================
  assign mem.en    = data_mem_go || instr_go;
  assign mem.addr  = data_mem_go ? data_addr : instr_word_addr;
  assign mem.wr_en = data_mem_go && data_wr_en;
  assign mem.wdata = data_wr_data;
  assign mem.mask  = data_mask;

  assign sys.en    = data_sys_go;
  assign sys.addr  = data_addr;
  assign sys.wr_en = data_wr_en;
  assign sys.wdata = data_wr_data;
  assign sys.mask  = data_mask;

  // ========================================
  // Acknowledge and response steering
  // ========================================
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      instr_ack     <= 1'b0;
      data_ack      <= 1'b0;
      data_from_sys <= 1'b0;
    end else begin
      instr_ack <= instr_go;
      data_ack  <= data_go;
      // Remember which slave answers the data access in flight
      if (data_go) begin
        data_from_sys <= data_is_sys;
      end
    end
  end

  // Fetches only ever come from memory
  assign instr_data   = mem.rdata;
  assign data_rd_data = data_from_sys ? sys.rdata : mem.rdata;

endmodule

`default_nettype wire

// File: design/snowflake_soc.sv
// Bus and peripheral top; the core drives the instr_* and data_* ports directly.
// LED outputs are active low, RSTN is synchronized internally.
`default_nettype none

module snowflake_soc (
  input  logic                 clk,
  input  logic                 RSTN,
  input  snowflake_pkg::addr_t instr_addr,
  input  logic                 instr_req,
  output snowflake_pkg::word_t instr_data,
  output logic                 instr_ack,
  input  snowflake_pkg::addr_t data_addr,
  input  snowflake_pkg::word_t data_wr_data,
  input  snowflake_pkg::mask_t data_mask,
  input  logic                 data_wr_en,
  input  logic                 data_req,
  output snowflake_pkg::word_t data_rd_data,
  output logic                 data_ack,
  output logic                 ledr,
  output logic                 ledg,
  output logic                 cat,
  output snowflake_pkg::seg_t  seg
);

  logic [1:0]          reset_sync;
  logic                rstz;
  logic                led_r;
  logic                led_g;
  logic                ssd_en;
  snowflake_pkg::seg_t ssd_a;
  snowflake_pkg::seg_t ssd_b;

  // ========================================
  // Reset synchronizer
  // ========================================
  always_ff @(posedge clk or negedge RSTN) begin
    if (!RSTN) begin
      reset_sync <= '0;
    end else begin
      reset_sync <= {reset_sync[0], 1'b1};
    end
  end

  assign rstz = reset_sync[1];

  // ========================================
  // Bus and slaves
  // ========================================
  snowflake_bus_if mem_bus ();
  snowflake_bus_if sys_bus ();

  snowflake_system_bus u_sysbus (
    .clk         (clk),
    .rstz        (rstz),
    .instr_addr  (instr_addr),
    .instr_req   (instr_req),
    .instr_data  (instr_data),
    .instr_ack   (instr_ack),
    .data_addr   (data_addr),
    .data_wr_data(data_wr_data),
    .data_mask   (data_mask),
    .data_wr_en  (data_wr_en),
    .data_req    (data_req),
    .data_rd_data(data_rd_data),
    .data_ack    (data_ack),
    .mem         (mem_bus.master),
    .sys         (sys_bus.master)
  );

  generic_spram #(.KB(snowflake_pkg::MEM_KB)) u_mem (
    .clk(clk),
    .bus(mem_bus.slave)
  );

  snowflake_sys_regs u_regs (
    .clk   (clk),
    .rstz  (rstz),
    .bus   (sys_bus.slave),
    .led_r (led_r),
    .led_g (led_g),
    .ssd_en(ssd_en),
    .ssd_a (ssd_a),
    .ssd_b (ssd_b)
  );

  // ========================================
  // Board outputs
  // ========================================
  snowflake_7sd_driver u_7sd (
    .clk (clk),
    .rstz(rstz),
    .en  (ssd_en),
    .a   (ssd_a),
    .b   (ssd_b),
    .disp(seg),
    .sel (cat)
  );

  // LEDs light on a low level
  assign ledr = ~led_r;
  assign ledg = ~led_g;

endmodule

`default_nettype wire

// File: verif/snowflake_properties.sv
// Bus timing checks, bound into the system bus; accept follows the arbitration rules.
`default_nettype none

module snowflake_properties (
  input logic                 clk,
  input logic                 rstz,
  input logic                 instr_req,
  input logic                 instr_ack,
  input logic                 data_req,
  input logic                 data_ack,
  input logic                 data_from_sys,
  input snowflake_pkg::addr_t data_addr
);

  timeunit 1ns;
  timeprecision 1ps;

  logic data_accept;
  logic instr_accept;

  // Data port has memory priority, register accesses never block fetches
  assign data_accept  = data_req && !data_ack;
  assign instr_accept = instr_req && !instr_ack &&
                        !(data_accept && data_addr[31:16] != snowflake_pkg::SYS_REGION);

  data_ack_follows: assert property (@(posedge clk) disable iff (!rstz)
    data_accept |=> data_ack)
    else $error("data request accepted without ack one cycle later");

  instr_ack_follows: assert property (@(posedge clk) disable iff (!rstz)
    instr_accept |=> instr_ack)
    else $error("fetch accepted without ack one cycle later");

  data_ack_needs_accept: assert property (@(posedge clk) disable iff (!rstz)
    data_ack |-> $past(data_accept))
    else $error("data ack without an accepted request");

  instr_ack_needs_accept: assert property (@(posedge clk) disable iff (!rstz)
    instr_ack |-> $past(instr_accept))
    else $error("fetch ack without an accepted request");

  data_ack_pulse: assert property (@(posedge clk) disable iff (!rstz)
    data_ack |=> !data_ack)
    else $error("data ack high for two cycles");

  instr_ack_pulse: assert property (@(posedge clk) disable iff (!rstz)
    instr_ack |=> !instr_ack)
    else $error("fetch ack high for two cycles");

  // Both acks together only when the data port went to the register block
  mem_one_port: assert property (@(posedge clk) disable iff (!rstz)
    (data_ack && instr_ack) |-> data_from_sys)
    else $error("memory answered both ports in the same cycle");

endmodule

bind snowflake_system_bus snowflake_properties u_props (
  .clk          (clk),
  .rstz         (rstz),
  .instr_req    (instr_req),
  .instr_ack    (instr_ack),
  .data_req     (data_req),
  .data_ack     (data_ack),
  .data_from_sys(data_from_sys),
  .data_addr    (data_addr)
);

`default_nettype wire

// File: verif/snowflake_tb.sv
// Plays the core on both ports with random traffic from a fixed seed.
// Memory is filled through the data port first, so every word the model reads is known.
`default_nettype none

module snowflake_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam int WORDS        = snowflake_pkg::MEM_KB * 256;
  localparam int N_DATA       = 600;
  localparam int N_FETCH      = 400;
  localparam int N_DISP       = 5;
  localparam int DISP_LEN     = 4 * snowflake_pkg::SSD_REFRESH;
  localparam int MAX_CYCLES   = 3 * (WORDS + N_DATA + N_FETCH + N_DISP)
                                + DISP_LEN + RESET_CYCLES + 32;

  logic                 clk;
  logic                 RSTN;
  snowflake_pkg::addr_t instr_addr;
  logic                 instr_req;
  snowflake_pkg::word_t instr_data;
  logic                 instr_ack;
  snowflake_pkg::addr_t data_addr;
  snowflake_pkg::word_t data_wr_data;
  snowflake_pkg::mask_t data_mask;
  logic                 data_wr_en;
  logic                 data_req;
  snowflake_pkg::word_t data_rd_data;
  logic                 data_ack;
  logic                 ledr;
  logic                 ledg;
  logic                 cat;
  snowflake_pkg::seg_t  seg;

  // Reference model
  snowflake_pkg::word_t mem_model [WORDS];
  logic                 m_led_r;
  logic                 m_led_g;
  logic                 m_ssd_en;
  snowflake_pkg::seg_t  m_ssd_a;
  snowflake_pkg::seg_t  m_ssd_b;
  logic                 exp_dack;
  logic                 exp_iack;
  logic                 exp_cat;
  int                   run;

  // Pending core accesses
  snowflake_pkg::addr_t dq_addr [$];
  snowflake_pkg::word_t dq_data [$];
  snowflake_pkg::mask_t dq_mask [$];
  logic                 dq_wr [$];
  snowflake_pkg::addr_t iq_addr [$];

  logic                 random_gaps;
  integer               seed;
  int                   cycles = 0;

  snowflake_soc DUT (
    .clk         (clk),
    .RSTN        (RSTN),
    .instr_addr  (instr_addr),
    .instr_req   (instr_req),
    .instr_data  (instr_data),
    .instr_ack   (instr_ack),
    .data_addr   (data_addr),
    .data_wr_data(data_wr_data),
    .data_mask   (data_mask),
    .data_wr_en  (data_wr_en),
    .data_req    (data_req),
    .data_rd_data(data_rd_data),
    .data_ack    (data_ack),
    .ledr        (ledr),
    .ledg        (ledg),
    .cat         (cat),
    .seg         (seg)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // ========================================
  // Compare tasks
  // ========================================
  task automatic check_word(input snowflake_pkg::word_t actual,
                            input snowflake_pkg::word_t expected, input string what);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t: %s is %h, expected %h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_seg(input snowflake_pkg::seg_t actual,
                           input snowflake_pkg::seg_t expected, input string what);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t: %s is %h, expected %h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "segment mismatch");
    end
  endtask

  task automatic check_level(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t: %s is %b, expected %b", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "level mismatch");
    end
  endtask

  // ========================================
  // Model helpers
  // ========================================
  function automatic logic in_sys(input snowflake_pkg::addr_t a);
    return a[31:16] == snowflake_pkg::SYS_REGION;
  endfunction

  function automatic snowflake_pkg::addr_t reg_addr(input logic [5:0] off);
    return {snowflake_pkg::SYS_REGION, 8'h00, off, 2'b00};
  endfunction

  function automatic snowflake_pkg::word_t reg_value(input logic [5:0] off);
    case (off)
      snowflake_pkg::REG_LEDR:   return {31'b0, m_led_r};
      snowflake_pkg::REG_LEDG:   return {31'b0, m_led_g};
      snowflake_pkg::REG_SSD_EN: return {31'b0, m_ssd_en};
      snowflake_pkg::REG_SSD_A:  return {25'b0, m_ssd_a};
      snowflake_pkg::REG_SSD_B:  return {25'b0, m_ssd_b};
      default:                   return '0;
    endcase
  endfunction

  // Pattern is a function of the full byte address
  function automatic snowflake_pkg::word_t fill_word(input snowflake_pkg::addr_t a);
    return (a * 32'h9e3779b1) ^ 32'h0badc0de;
  endfunction

  task automatic push_data(input snowflake_pkg::addr_t a, input snowflake_pkg::word_t w,
                           input snowflake_pkg::mask_t m, input logic wr);
    dq_addr.push_back(a);
    dq_data.push_back(w);
    dq_mask.push_back(m);
    dq_wr.push_back(wr);
  endtask

  task automatic push_random_data();
    snowflake_pkg::addr_t a;
    snowflake_pkg::word_t w;
    snowflake_pkg::mask_t m;
    int                   kind;
    kind = $random(seed) & 7;
    a    = $random(seed);
    w    = $random(seed);
    m    = 4'($random(seed));
    if (kind < 2) begin
      // Register region, offsets 0 to 7 so some are unmapped
      a[31:16] = snowflake_pkg::SYS_REGION;
      a[7:5]   = 3'b000;
    end else if (in_sys(a)) begin
      a[31:16] = 16'h0000;
    end
    push_data(a, w, m, 1'($random(seed)));
  endtask

  // Completes the data access whose ack was just seen
  task automatic finish_data();
    logic [snowflake_pkg::MEM_AW-1:0] idx;
    idx = data_addr[snowflake_pkg::MEM_AW+1:2];
    if (!data_wr_en) begin
      if (in_sys(data_addr)) begin
        check_word(data_rd_data, reg_value(data_addr[7:2]), "register readback");
      end else begin
        check_word(data_rd_data, mem_model[idx], "data memory read");
      end
    end else if (!in_sys(data_addr)) begin
      for (int i = 0; i < 4; i++) begin
        if (data_mask[i]) begin
          mem_model[idx][8*i +: 8] = data_wr_data[8*i +: 8];
        end
      end
    end else if (data_mask[0]) begin
      case (data_addr[7:2])
        snowflake_pkg::REG_LEDR:   m_led_r  = data_wr_data[0];
        snowflake_pkg::REG_LEDG:   m_led_g  = data_wr_data[0];
        snowflake_pkg::REG_SSD_EN: m_ssd_en = data_wr_data[0];
        snowflake_pkg::REG_SSD_A:  m_ssd_a  = data_wr_data[6:0];
        snowflake_pkg::REG_SSD_B:  m_ssd_b  = data_wr_data[6:0];
        default: ;
      endcase
    end
  endtask

  // ========================================
  // One clock cycle as the core
  // ========================================
  task automatic tick();
    logic                en_old;
    logic                next_d;
    snowflake_pkg::seg_t exp_seg;
    @(negedge clk);
    check_level(data_ack, exp_dack, "data_ack");
    check_level(instr_ack, exp_iack, "instr_ack");
    en_old = m_ssd_en;
    if (exp_dack) begin
      finish_data();
    end
    if (exp_iack) begin
      check_word(instr_data, mem_model[instr_addr[snowflake_pkg::MEM_AW+1:2]], "fetch");
    end
    // Display at the edge just passed uses the enable from before it
    if (!en_old) begin
      run     = 0;
      exp_cat = 1'b0;
    end else begin
      run = run + 1;
      if (run == snowflake_pkg::SSD_REFRESH) begin
        run     = 0;
        exp_cat = ~exp_cat;
      end
    end
    if (!m_ssd_en) begin
      exp_seg = '0;
    end else if (exp_cat) begin
      exp_seg = m_ssd_b;
    end else begin
      exp_seg = m_ssd_a;
    end
    check_level(ledr, ~m_led_r, "ledr");
    check_level(ledg, ~m_led_g, "ledg");
    check_level(cat, exp_cat, "cat");
    check_seg(seg, exp_seg, "seg");

    // Next request on each free port
    if (!data_req || exp_dack) begin
      data_req = 1'b0;
      if (dq_addr.size() > 0 && !(random_gaps && (($random(seed) & 3) == 0))) begin
        data_addr    = dq_addr.pop_front();
        data_wr_data = dq_data.pop_front();
        data_mask    = dq_mask.pop_front();
        data_wr_en   = dq_wr.pop_front();
        data_req     = 1'b1;
      end
    end
    if (!instr_req || exp_iack) begin
      instr_req = 1'b0;
      if (iq_addr.size() > 0) begin
        instr_addr = iq_addr.pop_front();
        instr_req  = 1'b1;
      end
    end

    // Acceptance at the coming edge, data wins memory
    next_d   = data_req && !exp_dack;
    exp_iack = instr_req && !exp_iack && !(next_d && !in_sys(data_addr));
    exp_dack = next_d;
  endtask

  task automatic drain();
    while (dq_addr.size() > 0 || iq_addr.size() > 0 || data_req || instr_req) begin
      tick();
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    seed         = 32'hde81401c;
    RSTN         = 1'b0;
    instr_addr   = '0;
    instr_req    = 1'b0;
    data_addr    = '0;
    data_wr_data = '0;
    data_mask    = '0;
    data_wr_en   = 1'b0;
    data_req     = 1'b0;
    m_led_r      = 1'b0;
    m_led_g      = 1'b0;
    m_ssd_en     = 1'b0;
    m_ssd_a      = '0;
    m_ssd_b      = '0;
    exp_dack     = 1'b0;
    exp_iack     = 1'b0;
    exp_cat      = 1'b0;
    run          = 0;
    random_gaps  = 1'b0;

    repeat (RESET_CYCLES) @(negedge clk);
    check_level(data_ack, 1'b0, "data_ack in reset");
    check_level(instr_ack, 1'b0, "instr_ack in reset");
    check_level(ledr, 1'b1, "ledr in reset");
    check_level(ledg, 1'b1, "ledg in reset");
    check_level(cat, 1'b0, "cat in reset");
    check_seg(seg, '0, "seg in reset");
    RSTN = 1'b1;
    repeat (4) tick();

    // Known contents everywhere
    for (int i = 0; i < WORDS; i++) begin
      push_data(snowflake_pkg::addr_t'(i) << 2, fill_word(snowflake_pkg::addr_t'(i) << 2),
                4'hf, 1'b1);
      mem_model[i] = fill_word(snowflake_pkg::addr_t'(i) << 2);
    end
    drain();

    // Overlapping random traffic on both ports
    random_gaps = 1'b1;
    for (int i = 0; i < N_DATA; i++) begin
      push_random_data();
    end
    for (int i = 0; i < N_FETCH; i++) begin
      iq_addr.push_back($random(seed));
    end
    drain();
    random_gaps = 1'b0;

    // Display on, watched over several refresh periods, then off
    push_data(reg_addr(snowflake_pkg::REG_SSD_A), $random(seed), 4'hf, 1'b1);
    push_data(reg_addr(snowflake_pkg::REG_SSD_B), $random(seed), 4'hf, 1'b1);
    push_data(reg_addr(snowflake_pkg::REG_SSD_EN), 32'h1, 4'hf, 1'b1);
    push_data(reg_addr(snowflake_pkg::REG_SSD_EN), 32'h0, 4'hf, 1'b0);
    drain();
    repeat (DISP_LEN) tick();
    push_data(reg_addr(snowflake_pkg::REG_SSD_EN), 32'h0, 4'hf, 1'b1);
    drain();
    repeat (8) tick();

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/snowflake_pkg.sv
design/snowflake_bus_if.sv
design/generic_spram.sv
design/snowflake_sys_regs.sv
design/snowflake_7sd_driver.sv
design/snowflake_system_bus.sv
design/snowflake_soc.sv
verif/snowflake_properties.sv
verif/snowflake_tb.sv

// File: Makefile
# Verilator flow for the snowflake bus and peripheral testbench
VERILATOR ?= verilator
TOP       := snowflake_tb
FILELIST  := list.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
